//--- Makefile
# Verilator flow for the data-memory Wishbone bridge
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_ycr_dmem_intf
FILELIST  ?= ycr_dmem_intf.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Finished with no errors

SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/ycr_dmem_pkg.sv
/*
 * Shared definitions for the data-memory Wishbone bridge
 * Bus widths, access width / command / response encodings
 * Core request, queued Wishbone request and completion structs
 */

package ycr_dmem_pkg;

   //------------------------------
   // Widths
   //------------------------------
   localparam int YCR_DMEM_AWIDTH = 32;                  // Core and WB address
   localparam int YCR_DMEM_DWIDTH = 32;                  // Core and WB data
   localparam int YCR_WB_SEL_W    = 4;                   // One select per byte lane

   //------------------------------
   // Encodings
   //------------------------------
   typedef enum logic [1:0] {
      DMEM_WIDTH_BYTE = 2'b00,                           // 8 bit access
      DMEM_WIDTH_HALF = 2'b01,                           // 16 bit access
      DMEM_WIDTH_WORD = 2'b10                            // 32 bit access
   } dmem_width_e;

   typedef enum logic {
      DMEM_CMD_RD = 1'b0,                                // Load
      DMEM_CMD_WR = 1'b1                                 // Store
   } dmem_cmd_e;

   typedef enum logic [1:0] {
      DMEM_RESP_IDLE = 2'b00,                            // Nothing returned this cycle
      DMEM_RESP_RDY  = 2'b01,                            // Access done
      DMEM_RESP_ERR  = 2'b10                             // Slave flagged an error
   } dmem_resp_e;

   //------------------------------
   // Request / response structs
   //------------------------------
   typedef struct packed {
      dmem_cmd_e                    cmd;                 // Read or write
      dmem_width_e                  width;               // Access size
      logic [YCR_DMEM_AWIDTH-1:0]   addr;                // Byte address
      logic [YCR_DMEM_DWIDTH-1:0]   wdata;               // Right aligned store data
   } dmem_req_t;

   typedef struct packed {
      logic                         we;                  // Write cycle
      logic [YCR_DMEM_AWIDTH-1:2]   adr;                 // Word address
      logic [YCR_DMEM_DWIDTH-1:0]   dat;                 // Lane shifted store data
      logic [YCR_WB_SEL_W-1:0]      sel;                 // Byte enables
      dmem_width_e                  width;               // Kept for read alignment
      logic [1:0]                   boff;                // Byte offset in word
   } wb_req_t;

   typedef struct packed {
      logic                         done;                // High for one cycle on ack or err
      logic                         err;                 // Slave answered with err
      logic [YCR_DMEM_DWIDTH-1:0]   rdata;               // Raw bus read data
      logic [1:0]                   boff;                // Offset of finished request
      dmem_width_e                  width;               // Width of finished request
   } wb_rsp_t;

endpackage : ycr_dmem_pkg

//--- dmem_bridge/ycr_dmem_req_queue.sv
/*
 * Core request queue
 * Level request / same-cycle ack, lane alignment of select and store data
 * Circular buffer of wb_req_t with read / write pointers and a count
 */

`timescale 1ns/1ps

module ycr_dmem_req_queue import ycr_dmem_pkg::*; #(
   parameter int QUEUE_DEPTH = 2                         // Power of two, at least 2
) (
   input  logic        core_clk_i,                       // Core clock
   input  logic        rst_i,                            // Internal reset
   input  logic        dmem_req_i,                       // Core request level
   input  dmem_req_t   dmem_req_pkt_i,                   // Core request fields
   output logic        dmem_req_ack_o,                   // Request taken this cycle
   output logic        head_valid_o,                     // Queue not empty
   output wb_req_t     head_o,                           // Oldest request
   input  logic        pop_i                             // Master takes the head
);

   localparam int PTR_W = $clog2(QUEUE_DEPTH);
   localparam int CNT_W = PTR_W + 1;

   wb_req_t            q_mem [QUEUE_DEPTH];              // Request storage
   logic [PTR_W-1:0]   wr_ptr;
   logic [PTR_W-1:0]   rd_ptr;
   logic [CNT_W-1:0]   q_cnt;                            // Entries held
   logic               q_full;
   logic               push;
   logic [1:0]         boff;
   wb_req_t            push_req;                         // Lane aligned request

   //------------------------------
   // Core handshake
   //------------------------------
   assign q_full         = (q_cnt == CNT_W'(QUEUE_DEPTH));
   assign dmem_req_ack_o = dmem_req_i && !q_full;        // Combinational ack
   assign push           = dmem_req_ack_o;
   assign boff           = dmem_req_pkt_i.addr[1:0];

   //------------------------------
   // Lane alignment
   //------------------------------
   always_comb begin
      push_req.we    = (dmem_req_pkt_i.cmd == DMEM_CMD_WR);
      push_req.adr   = dmem_req_pkt_i.addr[YCR_DMEM_AWIDTH-1:2]; // Word aligned
      push_req.dat   = dmem_req_pkt_i.wdata << {boff, 3'b000};   // Move to byte lane
      push_req.width = dmem_req_pkt_i.width;
      push_req.boff  = boff;
      case (dmem_req_pkt_i.width)
         DMEM_WIDTH_BYTE: push_req.sel = 4'b0001 << boff;      // Single lane
         DMEM_WIDTH_HALF: push_req.sel = 4'b0011 << boff;      // Two lanes
         default:         push_req.sel = 4'b1111;              // Full word
      endcase
   end

   // Aligned request written at the tail
   always_ff @(posedge core_clk_i) begin
      if (push) begin
         q_mem[wr_ptr] <= push_req;
      end
   end

   //------------------------------
   // Pointers and count
   //------------------------------
   always_ff @(posedge core_clk_i) begin
      if (rst_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         q_cnt  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;                     // Wraps at depth
         end
         if (pop_i) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop_i})
            2'b10:   q_cnt <= q_cnt + 1'b1;
            2'b01:   q_cnt <= q_cnt - 1'b1;
            default: q_cnt <= q_cnt;                     // Both or neither
         endcase
      end
   end

   assign head_valid_o = (q_cnt != '0);
   assign head_o       = q_mem[rd_ptr];

   //------------------------------
   // Checks
   //------------------------------
   // Master must only pop what the queue has announced
   a_no_pop_empty: assert property (@(posedge core_clk_i) disable iff (rst_i)
      pop_i |-> head_valid_o);

   // Core never issues an access that crosses a word
   a_lane_ok: assert property (@(posedge core_clk_i) disable iff (rst_i)
      dmem_req_i |->
         !(dmem_req_pkt_i.width == DMEM_WIDTH_HALF && boff == 2'd3) &&
         !(dmem_req_pkt_i.width == DMEM_WIDTH_WORD && boff != 2'd0));

endmodule : ycr_dmem_req_queue

//--- dmem_bridge/ycr_dmem_resp_fmt.sv
/*
 * Response formatter
 * Read data shift and zero extension by the lane rule
 * One-cycle ready / error code to the core per completion
 */

`timescale 1ns/1ps

module ycr_dmem_resp_fmt import ycr_dmem_pkg::*; (
   input  logic                          core_clk_i,     // Core clock
   input  logic                          rst_i,          // Internal reset
   input  wb_rsp_t                       rsp_i,          // Completion from master
   output logic [YCR_DMEM_DWIDTH-1:0]    dmem_rdata_o,   // Right aligned load data
   output dmem_resp_e                    dmem_resp_o     // Response code
);

   logic [YCR_DMEM_DWIDTH-1:0] rdata_shift;             // Lane moved to bit 0
   logic [YCR_DMEM_DWIDTH-1:0] rdata_ext;               // Zero extended by width
   logic [YCR_DMEM_DWIDTH-1:0] rdata_q;
   dmem_resp_e                 resp_q;

   //------------------------------
   // Alignment
   //------------------------------
   assign rdata_shift = rsp_i.rdata >> {rsp_i.boff, 3'b000};

   always_comb begin
      case (rsp_i.width)
         DMEM_WIDTH_BYTE: rdata_ext = {{(YCR_DMEM_DWIDTH-8){1'b0}}, rdata_shift[7:0]};
         DMEM_WIDTH_HALF: rdata_ext = {{(YCR_DMEM_DWIDTH-16){1'b0}}, rdata_shift[15:0]};
         default:         rdata_ext = rdata_shift;      // Full word
      endcase
   end

   //------------------------------
   // Output register
   //------------------------------
   always_ff @(posedge core_clk_i) begin
      if (rst_i) begin
         resp_q  <= DMEM_RESP_IDLE;
         rdata_q <= '0;
      end else if (rsp_i.done) begin
         resp_q  <= rsp_i.err ? DMEM_RESP_ERR : DMEM_RESP_RDY;
         // Error returns no data
         rdata_q <= rsp_i.err ? '0 : rdata_ext;
      end else begin
         resp_q  <= DMEM_RESP_IDLE;                      // Single cycle response
         rdata_q <= '0;                                  // Zero between responses
      end
   end

   assign dmem_rdata_o = rdata_q;
   assign dmem_resp_o  = resp_q;

endmodule : ycr_dmem_resp_fmt

//--- dmem_bridge/ycr_dmem_wb_master.sv
/*
 * Wishbone classic master
 * Idle / busy FSM, one single-word cycle per queued request
 * Completion with raw read data and error flag back to the formatter
 */

`timescale 1ns/1ps

module ycr_dmem_wb_master import ycr_dmem_pkg::*; (
   input  logic                          core_clk_i,     // Core clock
   input  logic                          rst_i,          // Internal reset
   input  logic                          head_valid_i,   // Queue has a request
   input  wb_req_t                       head_i,         // Oldest request
   output logic                          pop_o,          // Take the head
   output logic                          wbd_stb_o,      // Strobe
   output logic                          wbd_cyc_o,      // Cycle
   output logic                          wbd_we_o,       // Write
   output logic [YCR_DMEM_AWIDTH-1:0]    wbd_adr_o,      // Word aligned address
   output logic [YCR_DMEM_DWIDTH-1:0]    wbd_dat_o,      // Store data
   output logic [YCR_WB_SEL_W-1:0]       wbd_sel_o,      // Byte enables
   input  logic [YCR_DMEM_DWIDTH-1:0]    wbd_dat_i,      // Load data
   input  logic                          wbd_ack_i,      // Acknowledge
   input  logic                          wbd_err_i,      // Error
   output wb_rsp_t                       rsp_o           // Completion
);

   typedef enum logic {
      WB_IDLE = 1'b0,                                    // Waiting for a request
      WB_BUSY = 1'b1                                     // Cycle on the bus
   } wb_state_e;

   wb_state_e                  state;
   logic                       stb_q;
   logic                       we_q;
   logic [YCR_DMEM_AWIDTH-1:2] adr_q;                    // Bus payload
   logic [YCR_DMEM_DWIDTH-1:0] dat_q;
   logic [YCR_WB_SEL_W-1:0]    sel_q;
   dmem_width_e                width_q;                  // Kept for the completion
   logic [1:0]                 boff_q;
   logic                       bus_end;                  // Ack or err seen in busy

   assign pop_o   = (state == WB_IDLE) && head_valid_i;
   assign bus_end = (state == WB_BUSY) && (wbd_ack_i || wbd_err_i);

   //------------------------------
   // FSM and control flops
   //------------------------------
   always_ff @(posedge core_clk_i) begin
      if (rst_i) begin
         state <= WB_IDLE;
         stb_q <= 1'b0;
         we_q  <= 1'b0;
      end else begin
         case (state)
            WB_IDLE: begin
               if (pop_o) begin
                  state <= WB_BUSY;
                  stb_q <= 1'b1;                         // Strobe one cycle after head
                  we_q  <= head_i.we;
               end
            end
            default: begin
               if (bus_end) begin
                  state <= WB_IDLE;
                  stb_q <= 1'b0;                         // Drop in the cycle after ack
                  we_q  <= 1'b0;
               end
            end
         endcase
      end
   end

   //------------------------------
   // Bus payload
   //------------------------------
   always_ff @(posedge core_clk_i) begin
      if (pop_o) begin
         adr_q   <= head_i.adr;
         dat_q   <= head_i.dat;
         sel_q   <= head_i.sel;
         width_q <= head_i.width;
         boff_q  <= head_i.boff;
      end
   end

   assign wbd_stb_o = stb_q;
   assign wbd_cyc_o = stb_q;                             // Classic single cycle
   assign wbd_we_o  = we_q;
   assign wbd_adr_o = {adr_q, 2'b00};
   assign wbd_dat_o = dat_q;
   assign wbd_sel_o = sel_q;

   //------------------------------
   // Completion
   //------------------------------
   always_comb begin
      rsp_o.done  = bus_end;                             // High in the ack cycle only
      rsp_o.err   = bus_end && wbd_err_i;
      rsp_o.rdata = wbd_dat_i;                           // Aligned in the formatter
      rsp_o.boff  = boff_q;
      rsp_o.width = width_q;
   end

   // Slave sees a steady request until it answers
   a_bus_stable: assert property (@(posedge core_clk_i) disable iff (rst_i)
      wbd_stb_o && !(wbd_ack_i || wbd_err_i) |=>
         wbd_stb_o && $stable({wbd_we_o, wbd_adr_o, wbd_dat_o, wbd_sel_o}));

endmodule : ycr_dmem_wb_master

//--- source/ycr_dmem_intf.sv
/*
 * Data-memory interface top level
 * Reset stretcher, request queue, Wishbone master, response formatter
 */

`timescale 1ns/1ps

module ycr_dmem_intf import ycr_dmem_pkg::*; #(
   parameter int RST_STAGES  = 2,                        // Internal reset stretch
   parameter int QUEUE_DEPTH = 2                         // Pending request slots
) (
   input  logic                          core_clk_i,     // Core clock
   input  logic                          reset_i,        // External reset

   // Core data port
   input  logic                          dmem_req_i,     // Request level
   input  dmem_req_t                     dmem_req_pkt_i, // Request fields
   output logic                          dmem_req_ack_o, // Request taken
   output logic [YCR_DMEM_DWIDTH-1:0]    dmem_rdata_o,   // Load data
   output dmem_resp_e                    dmem_resp_o,    // Response code

   // Wishbone master port
   output logic                          wbd_stb_o,      // Strobe
   output logic                          wbd_cyc_o,      // Cycle
   output logic                          wbd_we_o,       // Write
   output logic [YCR_DMEM_AWIDTH-1:0]    wbd_adr_o,      // Address
   output logic [YCR_DMEM_DWIDTH-1:0]    wbd_dat_o,      // Store data
   output logic [YCR_WB_SEL_W-1:0]       wbd_sel_o,      // Byte enables
   input  logic [YCR_DMEM_DWIDTH-1:0]    wbd_dat_i,      // Load data
   input  logic                          wbd_ack_i,      // Acknowledge
   input  logic                          wbd_err_i       // Error
);

   logic      core_rst;                                  // Stretched reset
   logic      head_valid;
   wb_req_t   head_req;
   logic      head_pop;
   wb_rsp_t   wb_rsp;

   //------------------------------
   // Reset
   //------------------------------
   ycr_rst_stretch #(
      .RST_STAGES     (RST_STAGES)
   ) u_rst_stretch (
      .core_clk_i     (core_clk_i),
      .reset_i        (reset_i),
      .rst_o          (core_rst)
   );

   //------------------------------
   // Request path
   //------------------------------
   ycr_dmem_req_queue #(
      .QUEUE_DEPTH    (QUEUE_DEPTH)
   ) u_req_queue (
      .core_clk_i     (core_clk_i),
      .rst_i          (core_rst),
      .dmem_req_i     (dmem_req_i),
      .dmem_req_pkt_i (dmem_req_pkt_i),
      .dmem_req_ack_o (dmem_req_ack_o),
      .head_valid_o   (head_valid),
      .head_o         (head_req),
      .pop_i          (head_pop)
   );

   ycr_dmem_wb_master u_wb_master (
      .core_clk_i     (core_clk_i),
      .rst_i          (core_rst),
      .head_valid_i   (head_valid),
      .head_i         (head_req),
      .pop_o          (head_pop),
      .wbd_stb_o      (wbd_stb_o),
      .wbd_cyc_o      (wbd_cyc_o),
      .wbd_we_o       (wbd_we_o),
      .wbd_adr_o      (wbd_adr_o),
      .wbd_dat_o      (wbd_dat_o),
      .wbd_sel_o      (wbd_sel_o),
      .wbd_dat_i      (wbd_dat_i),
      .wbd_ack_i      (wbd_ack_i),
      .wbd_err_i      (wbd_err_i),
      .rsp_o          (wb_rsp)
   );

   //------------------------------
   // Response path
   //------------------------------
   ycr_dmem_resp_fmt u_resp_fmt (
      .core_clk_i     (core_clk_i),
      .rst_i          (core_rst),
      .rsp_i          (wb_rsp),
      .dmem_rdata_o   (dmem_rdata_o),
      .dmem_resp_o    (dmem_resp_o)
   );

endmodule : ycr_dmem_intf

//--- source/ycr_rst_stretch.sv
/*
 * Synchronous reset stretcher
 * Holds the internal reset for RST_STAGES cycles after the external one ends
 */

`timescale 1ns/1ps

module ycr_rst_stretch #(
   parameter int RST_STAGES = 2                          // Extra cycles of reset
) (
   input  logic   core_clk_i,                            // Core clock
   input  logic   reset_i,                               // External reset, active high
   output logic   rst_o                                  // Stretched internal reset
);

   logic [RST_STAGES-1:0] rst_sr;                        // Ones drain out from the top

   //------------------------------
   // Shift chain
   //------------------------------
   always_ff @(posedge core_clk_i) begin
      if (reset_i) begin
         rst_sr <= '1;                                   // Refill on every reset cycle
      end else begin
         rst_sr <= rst_sr << 1;                          // Zero enters at the bottom
      end
   end

   // Last stage feeds every block in the bridge
   assign rst_o = rst_sr[RST_STAGES-1];

endmodule : ycr_rst_stretch

//--- testbench/tb_clk_gen.sv
/*
 * Testbench clock and reset generator
 * Free running clock, reset held for a fixed number of cycles
 */

`timescale 1ns/1ps

module tb_clk_gen #(
   parameter int PERIOD_NS  = 8,                         // Clock period
   parameter int RST_CYCLES = 10                         // Cycles of reset
) (
   output logic   clk_o,                                 // Core clock
   output logic   reset_o                                // Active high reset
);

   initial begin
      clk_o = 1'b0;
      forever begin
         #(PERIOD_NS / 2) clk_o = ~clk_o;
      end
   end

   // Release 1 ns after the edge as the stimulus does
   initial begin
      reset_o = 1'b1;
      repeat (RST_CYCLES) @(posedge clk_o);
      #1 reset_o = 1'b0;
   end

endmodule : tb_clk_gen

//--- testbench/tb_ycr_dmem_intf.sv
/*
 * Testbench top for the data-memory Wishbone bridge
 * Wishbone slave model with random wait states and error window
 * Stimulus file reader, in-order response checker, typed compare tasks
 */

`timescale 1ns/1ps

module tb_ycr_dmem_intf import ycr_dmem_pkg::*; ();

   localparam int          RST_STAGES  = 2;
   localparam int          QUEUE_DEPTH = 2;
   localparam int          TIMEOUT     = 200;           // Cycles allowed per wait
   localparam int          MAX_WAIT    = 5;             // Most slave wait states
   localparam logic [31:0] SEED        = 32'h1b69_3f09;

   typedef struct packed {
      logic [8*24-1:0]            name;                 // Test name from the file
      logic                       is_rd;                // Read data is compared
      logic [YCR_DMEM_DWIDTH-1:0] rdata;
      dmem_resp_e                 resp;
   } exp_t;

   logic                         core_clk;
   logic                         reset;
   logic                         dmem_req;
   dmem_req_t                    dmem_req_pkt;
   logic                         dmem_req_ack;
   logic [YCR_DMEM_DWIDTH-1:0]   dmem_rdata;
   dmem_resp_e                   dmem_resp;
   logic                         wbd_stb;
   logic                         wbd_cyc;
   logic                         wbd_we;
   logic [YCR_DMEM_AWIDTH-1:0]   wbd_adr;
   logic [YCR_DMEM_DWIDTH-1:0]   wbd_wdat;
   logic [YCR_WB_SEL_W-1:0]      wbd_sel;
   logic [YCR_DMEM_DWIDTH-1:0]   wbd_rdat;
   logic                         wbd_ack;
   logic                         wbd_err;

   logic [YCR_DMEM_DWIDTH-1:0]   slv_mem [256];         // Slave word memory
   logic                         slv_active;            // Cycle being served
   int unsigned                  slv_wait;
   exp_t                         exp_q [$];             // Responses still owed
   int                           pass_cnt;
   int                           fail_cnt;
   int                           stall_cnt;             // Cycles with ack held low
   logic                         abort;

   tb_clk_gen #(
      .PERIOD_NS      (8),
      .RST_CYCLES     (10)
   ) u_clk_gen (
      .clk_o          (core_clk),
      .reset_o        (reset)
   );

   ycr_dmem_intf #(
      .RST_STAGES     (RST_STAGES),
      .QUEUE_DEPTH    (QUEUE_DEPTH)
   ) DUT (
      .core_clk_i     (core_clk),
      .reset_i        (reset),
      .dmem_req_i     (dmem_req),
      .dmem_req_pkt_i (dmem_req_pkt),
      .dmem_req_ack_o (dmem_req_ack),
      .dmem_rdata_o   (dmem_rdata),
      .dmem_resp_o    (dmem_resp),
      .wbd_stb_o      (wbd_stb),
      .wbd_cyc_o      (wbd_cyc),
      .wbd_we_o       (wbd_we),
      .wbd_adr_o      (wbd_adr),
      .wbd_dat_o      (wbd_wdat),
      .wbd_sel_o      (wbd_sel),
      .wbd_dat_i      (wbd_rdat),
      .wbd_ack_i      (wbd_ack),
      .wbd_err_i      (wbd_err)
   );

   //------------------------------
   // Wishbone slave model
   //------------------------------
   task automatic slave_answer();
      logic [7:0] idx;
      idx = wbd_adr[9:2];                                // 256 word window
      if (wbd_adr[31]) begin
         wbd_err = 1'b1;                                 // Upper half is unmapped
      end else begin
         if (wbd_we) begin
            for (int b = 0; b < YCR_WB_SEL_W; b++) begin
               if (wbd_sel[b]) begin
                  slv_mem[idx][8*b +: 8] = wbd_wdat[8*b +: 8];
               end
            end
         end else begin
            wbd_rdat = slv_mem[idx];
         end
         wbd_ack = 1'b1;
      end
   endtask

   initial begin
      wbd_ack    = 1'b0;
      wbd_err    = 1'b0;
      wbd_rdat   = '0;
      slv_active = 1'b0;
      slv_wait   = 0;
      for (int i = 0; i < 256; i++) begin
         slv_mem[i] = '0;
      end
      void'($urandom(SEED));
      forever begin
         @(posedge core_clk);
         #1;
         if (wbd_ack || wbd_err) begin
            wbd_ack    = 1'b0;                           // Master saw the answer
            wbd_err    = 1'b0;
            wbd_rdat   = '0;
            slv_active = 1'b0;
         end else if (wbd_stb && wbd_cyc) begin
            if (!slv_active) begin
               slv_active = 1'b1;
               slv_wait   = $urandom_range(MAX_WAIT, 0);
            end
            if (slv_wait == 0) begin
               slave_answer();
            end else begin
               slv_wait--;
            end
         end
      end
   end

   //------------------------------
   // Compare tasks
   //------------------------------
   task automatic check_rdata(input logic [8*24-1:0] name,
                              input logic [YCR_DMEM_DWIDTH-1:0] expected,
                              input logic [YCR_DMEM_DWIDTH-1:0] actual,
                              output bit ok);
      ok = (actual === expected);
      if (!ok) begin
         $display("ERROR %0s: read data expected %08h, actual %08h", name, expected, actual);
      end
   endtask

   task automatic check_resp(input logic [8*24-1:0] name,
                             input dmem_resp_e expected,
                             input dmem_resp_e actual,
                             output bit ok);
      ok = (actual === expected);
      if (!ok) begin
         $display("ERROR %0s: response expected %s (%0d), actual %s (%0d)",
                  name, expected.name(), expected, actual.name(), actual);
      end
   endtask

   // Responses arrive in issue order, one per request
   task automatic score_response();
      exp_t item;
      bit   ok_resp;
      bit   ok_data;
      if (exp_q.size() == 0) begin
         $display("Response code %0d came back with no request outstanding", dmem_resp);
         fail_cnt++;
      end else begin
         item    = exp_q.pop_front();
         ok_data = 1'b1;
         check_resp(item.name, item.resp, dmem_resp, ok_resp);
         if (item.is_rd) begin
            check_rdata(item.name, item.rdata, dmem_rdata, ok_data);
         end
         if (ok_resp && ok_data) begin
            pass_cnt++;
            $display("PASS  %0s", item.name);
         end else begin
            fail_cnt++;
         end
      end
   endtask

   always @(negedge core_clk) begin
      if (!reset && dmem_resp != DMEM_RESP_IDLE) begin
         score_response();
      end
   end

   //------------------------------
   // Driver tasks
   //------------------------------
   function automatic bit outputs_idle();
      return (dmem_req_ack === 1'b0) && (wbd_stb === 1'b0) &&
             (wbd_cyc === 1'b0) && (wbd_we === 1'b0) &&
             (dmem_resp === DMEM_RESP_IDLE) && (dmem_rdata === '0);
   endfunction

   task automatic test_reset_outputs();
      int cyc;
      bit ok;
      ok  = 1'b1;
      cyc = 0;
      repeat (2) @(negedge core_clk);                    // Stretcher filled by now
      while (reset && cyc < TIMEOUT) begin
         ok &= outputs_idle();
         @(negedge core_clk);
         cyc++;
      end
      if (reset) begin
         $display("Timeout waiting for the end of reset");
         abort = 1'b1;
         ok    = 1'b0;
      end
      repeat (RST_STAGES + 3) begin
         ok &= outputs_idle();
         @(negedge core_clk);
      end
      if (ok) begin
         pass_cnt++;
         $display("PASS  reset_outputs");
      end else begin
         fail_cnt++;
         $display("reset_outputs: an output of the core or bus side was not idle around reset");
      end
   endtask

   // Entered 1 ns after a rising edge, leaves at the same point
   task automatic issue_req(input dmem_req_t pkt, input exp_t item);
      int cyc;
      dmem_req     = 1'b1;
      dmem_req_pkt = pkt;
      cyc          = 0;
      @(negedge core_clk);
      while (!dmem_req_ack && cyc < TIMEOUT) begin
         stall_cnt++;                                    // Core holds while the queue is full
         @(negedge core_clk);
         cyc++;
      end
      if (!dmem_req_ack) begin
         $display("Timeout waiting for the request acknowledge of %0s", item.name);
         fail_cnt++;
         abort = 1'b1;
      end else begin
         exp_q.push_back(item);
      end
      @(posedge core_clk);
      #1;
      dmem_req = 1'b0;
   endtask

   task automatic wait_responses();
      int cyc;
      cyc = 0;
      while (exp_q.size() != 0 && cyc < TIMEOUT) begin
         @(negedge core_clk);
         cyc++;
      end
      if (exp_q.size() != 0) begin
         $display("Timeout waiting for %0d outstanding responses", exp_q.size());
         fail_cnt++;
         abort = 1'b1;
      end
      @(posedge core_clk);
      #1;
   endtask

   //------------------------------
   // Main sequence
   //------------------------------
   initial begin
      int              fd;
      int              n;
      int              wait_flag;
      string           line;
      logic [8*24-1:0] name_s;
      logic [15:0]     cmd_s;
      logic [7:0]      width_s;
      logic [23:0]     resp_s;
      logic [31:0]     addr_v;
      logic [31:0]     wdata_v;
      logic [31:0]     rdata_v;
      dmem_req_t       pkt;
      exp_t            item;

      dmem_req     = 1'b0;
      dmem_req_pkt = '0;
      pass_cnt     = 0;
      fail_cnt     = 0;
      stall_cnt    = 0;
      abort        = 1'b0;

      test_reset_outputs();
      fd = $fopen("testbench/ycr_dmem_stimulus.txt", "r");
      if (fd == 0) begin
         $display("Could not open testbench/ycr_dmem_stimulus.txt");
         fail_cnt++;
         abort = 1'b1;
      end
      @(posedge core_clk);
      #1;
      while (!abort && !$feof(fd)) begin
         if ($fgets(line, fd) == 0) begin
            break;
         end
         if (line.len() < 2 || line.getc(0) == "#") begin
            continue;                                    // Blank or column notes
         end
         n = $sscanf(line, "%s %s %s %h %h %h %s %d", name_s, cmd_s, width_s,
                     addr_v, wdata_v, rdata_v, resp_s, wait_flag);
         if (n != 8) begin
            $display("Stimulus line has %0d fields instead of 8: %s", n, line);
            fail_cnt++;
            continue;
         end
         pkt.cmd   = (cmd_s == "WR") ? DMEM_CMD_WR : DMEM_CMD_RD;
         case (width_s)
            "B":     pkt.width = DMEM_WIDTH_BYTE;
            "H":     pkt.width = DMEM_WIDTH_HALF;
            default: pkt.width = DMEM_WIDTH_WORD;
         endcase
         pkt.addr   = addr_v;
         pkt.wdata  = wdata_v;
         item.name  = name_s;
         item.is_rd = (cmd_s == "RD");
         item.rdata = rdata_v;
         item.resp  = (resp_s == "ERR") ? DMEM_RESP_ERR : DMEM_RESP_RDY;
         issue_req(pkt, item);
         if (!abort && wait_flag != 0) begin
            wait_responses();
         end
      end
      if (fd != 0) begin
         $fclose(fd);
      end
      if (!abort) begin
         wait_responses();
      end
      // Back to back requests must have met a full queue at least once
      if (!abort) begin
         if (stall_cnt > 0) begin
            pass_cnt++;
            $display("PASS  backpressure_seen (%0d stall cycles)", stall_cnt);
         end else begin
            fail_cnt++;
            $display("backpressure_seen: acknowledge never dropped for a held request");
         end
      end

      $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0 && pass_cnt > 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule : tb_ycr_dmem_intf

//--- testbench/ycr_dmem_stimulus.txt
# name  cmd(RD/WR)  width(B/H/W)  addr(hex)  wdata(hex)  exp_rdata(hex, reads only)  exp_resp(RDY/ERR)
# wait: 1 = wait for this response before the next request, 0 = issue the next one at once
wr_word_a     WR W 00000010 A5C31234 00000000 RDY 1
rd_word_a     RD W 00000010 00000000 A5C31234 RDY 1
wr_byte_0     WR B 00000020 CCCCCC11 00000000 RDY 1
wr_byte_1     WR B 00000021 CCCCCC22 00000000 RDY 1
wr_byte_2     WR B 00000022 CCCCCC33 00000000 RDY 1
wr_byte_3     WR B 00000023 CCCCCC44 00000000 RDY 1
rd_word_b     RD W 00000020 00000000 44332211 RDY 1
rd_byte_3     RD B 00000023 00000000 00000044 RDY 1
rd_byte_1     RD B 00000021 00000000 00000022 RDY 1
rd_half_2     RD H 00000022 00000000 00004433 RDY 1
wr_half_0     WR H 00000030 DDDD8081 00000000 RDY 1
wr_half_2     WR H 00000032 DDDDF0E1 00000000 RDY 1
rd_word_c     RD W 00000030 00000000 F0E18081 RDY 1
rd_half_0     RD H 00000030 00000000 00008081 RDY 1
rd_half_2c    RD H 00000032 00000000 0000F0E1 RDY 1
rd_byte_2c    RD B 00000032 00000000 000000E1 RDY 1
rd_byte_3c    RD B 00000033 00000000 000000F0 RDY 1
rd_err        RD W 80000040 00000000 00000000 ERR 1
wr_err        WR B 80000005 000000FF 00000000 ERR 1
rd_after_err  RD W 00000010 00000000 A5C31234 RDY 1
b2b_wr_0      WR W 00000040 11112222 00000000 RDY 0
b2b_wr_1      WR W 00000044 33334444 00000000 RDY 0
b2b_wr_2      WR B 00000048 000000A1 00000000 RDY 0
b2b_wr_3      WR H 0000004A 0000B2C3 00000000 RDY 0
b2b_rd_0      RD W 00000040 00000000 11112222 RDY 0
b2b_err       RD W 80000044 00000000 00000000 ERR 0
b2b_rd_1      RD W 00000044 00000000 33334444 RDY 0
b2b_rd_2      RD W 00000048 00000000 B2C300A1 RDY 0
b2b_rd_3      RD H 0000004A 00000000 0000B2C3 RDY 0
b2b_rd_4      RD B 00000049 00000000 00000000 RDY 1

//--- ycr_dmem_intf.f
common/ycr_dmem_pkg.sv
source/ycr_rst_stretch.sv
dmem_bridge/ycr_dmem_req_queue.sv
dmem_bridge/ycr_dmem_wb_master.sv
dmem_bridge/ycr_dmem_resp_fmt.sv
source/ycr_dmem_intf.sv
testbench/tb_clk_gen.sv
testbench/tb_ycr_dmem_intf.sv
